/* src/c4_pkg.sv */
`default_nettype none

package c4_pkg;

	localparam int ROWS = 8;
	localparam int COLS = 8;
	localparam int ROW_BITS = 3;
	localparam int COL_BITS = 3;
	localparam int WINDOWS = 13;
	localparam int LINE_LEN = 4;

	typedef enum logic [1:0] {
		EMPTY   = 2'b00,
		PLAYER1 = 2'b01,
		PLAYER2 = 2'b10
	} cell_t;

	typedef logic [ROW_BITS-1:0] row_t;
	typedef logic [COL_BITS-1:0] col_t;
	typedef logic [ROW_BITS:0] fill_t;

	// Row 0 is the bottom of a column
	typedef cell_t [ROWS-1:0] column_t;
	typedef column_t [COLS-1:0] board_t;

	typedef struct packed {
		logic right;
		logic left;
		logic drop;
	} buttons_t;

	typedef struct packed {
		logic  valid;
		col_t  col;
		cell_t piece;
	} drop_req_t;

	typedef logic [3:0] window_t;

	typedef struct packed {
		logic signed [1:0] drow;
		logic signed [1:0] dcol;
		logic [1:0]        offset;
	} win_geom_t;

	// Cell j lies at the new piece plus (j - offset) steps
	function automatic win_geom_t window_geom(window_t w);
		win_geom_t g;
		if (w == 4'd0)
		begin
			g.drow = -2'sd1;
			g.dcol = 2'sd0;
			g.offset = 2'd0;
		end
		else if (w <= 4'd4)
		begin
			g.drow = 2'sd0;
			g.dcol = 2'sd1;
			g.offset = 2'(w - 4'd1);
		end
		else if (w <= 4'd8)
		begin
			g.drow = 2'sd1;
			g.dcol = 2'sd1;
			g.offset = 2'(w - 4'd5);
		end
		else
		begin
			g.drow = -2'sd1;
			g.dcol = 2'sd1;
			g.offset = 2'(w - 4'd9);
		end
		return g;
	endfunction

endpackage

`default_nettype wire

/* src/button_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module button_sync (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             right_pin,
	input  logic             left_pin,
	input  logic             drop_pin,
	output c4_pkg::buttons_t btn
);

	// Bit order follows buttons_t with right as the top bit
	logic [2:0] stage1;
	logic [2:0] stage2;
	logic [2:0] stage3;
	logic [2:0] press;

	// Pins idle high so the chain resets high
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			stage1 <= '1;
			stage2 <= '1;
			stage3 <= '1;
		end
		else
		begin
			stage1 <= {right_pin, left_pin, drop_pin};
			stage2 <= stage1;
			stage3 <= stage2;
		end
	end

	assign press = stage3 & ~stage2;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			btn <= '0;
		else
		begin
			// Opposite moves in one cycle cancel
			btn.right <= press[2] & ~press[1];
			btn.left <= press[1] & ~press[2];
			btn.drop <= press[0];
		end
	end

endmodule

`default_nettype wire

/* src/turn_control.sv */
`timescale 1ns/1ps
`default_nettype none

module turn_control (
	input  logic                               clk,
	input  logic                               rst_n,
	input  c4_pkg::buttons_t                   btn,
	input  c4_pkg::fill_t [c4_pkg::COLS-1:0]   fill,
	input  logic                               hit,
	output c4_pkg::drop_req_t                  drop_req,
	output c4_pkg::window_t                    win_idx,
	output c4_pkg::row_t                       piece_row,
	output c4_pkg::col_t                       current_col,
	output c4_pkg::cell_t                      current_player,
	output logic                               game_over
);

	typedef enum logic [2:0] {
		IDLE,
		PLACE,
		CHECK,
		DONE,
		WIN
	} state_t;

	state_t state;
	c4_pkg::fill_t col_fill;
	logic col_full;

	assign col_fill = fill[current_col];
	assign col_full = (col_fill == c4_pkg::fill_t'(c4_pkg::ROWS));

	// Request lives for the single PLACE cycle
	assign drop_req.valid = (state == PLACE) && !col_full;
	assign drop_req.col = current_col;
	assign drop_req.piece = current_player;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			current_col <= '0;
			current_player <= c4_pkg::PLAYER1;
			game_over <= 1'b0;
			win_idx <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (btn.right)
						current_col <= (current_col == c4_pkg::col_t'(c4_pkg::COLS - 1)) ?
							'0 : current_col + 1'b1;
					else if (btn.left)
						current_col <= (current_col == '0) ?
							c4_pkg::col_t'(c4_pkg::COLS - 1) : current_col - 1'b1;
					if (btn.drop)
						state <= PLACE;
				end
				PLACE:
				begin
					win_idx <= '0;
					// A full column keeps the turn
					state <= col_full ? IDLE : CHECK;
				end
				CHECK:
				begin
					if (hit)
						game_over <= 1'b1;
					if (win_idx == c4_pkg::window_t'(c4_pkg::WINDOWS - 1))
						state <= DONE;
					else
						win_idx <= win_idx + 1'b1;
				end
				DONE:
				begin
					if (game_over)
						state <= WIN;
					else
					begin
						current_player <= (current_player == c4_pkg::PLAYER1) ?
							c4_pkg::PLAYER2 : c4_pkg::PLAYER1;
						state <= IDLE;
					end
				end
				WIN:
					state <= WIN;
				default:
					state <= IDLE;
			endcase
		end
	end

	// Landing row of the new piece is held through the scan
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			piece_row <= '0;
		else if (state == PLACE)
			piece_row <= c4_pkg::row_t'(col_fill);
	end

endmodule

`default_nettype wire

/* src/column_stack.sv */
`timescale 1ns/1ps
`default_nettype none

module column_stack #(
	parameter int IDX = 0
) (
	input  logic              clk,
	input  logic              rst_n,
	input  c4_pkg::drop_req_t drop_req,
	output c4_pkg::column_t   col_data,
	output c4_pkg::fill_t     fill
);

	logic write;

	assign write = drop_req.valid
		&& (drop_req.col == c4_pkg::col_t'(IDX))
		&& (fill < c4_pkg::fill_t'(c4_pkg::ROWS));

	// Fill count doubles as the row of the next free cell
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int r = 0; r < c4_pkg::ROWS; r++)
				col_data[r] <= c4_pkg::EMPTY;
			fill <= '0;
		end
		else if (write)
		begin
			col_data[fill[c4_pkg::ROW_BITS-1:0]] <= drop_req.piece;
			fill <= fill + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* src/line_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module line_checker (
	input  c4_pkg::board_t  board,
	input  c4_pkg::window_t win_idx,
	input  c4_pkg::row_t    piece_row,
	input  c4_pkg::col_t    piece_col,
	input  c4_pkg::cell_t   piece,
	output logic            hit
);

	c4_pkg::win_geom_t geom;
	logic [c4_pkg::LINE_LEN-1:0] cell_match;

	assign geom = c4_pkg::window_geom(win_idx);

	always_comb
	begin
		int step;
		int r;
		int c;
		for (int j = 0; j < c4_pkg::LINE_LEN; j++)
		begin
			step = j - int'(geom.offset);
			r = int'(piece_row) + step * int'(geom.drow);
			c = int'(piece_col) + step * int'(geom.dcol);
			// Cells off the board never match
			if (r < 0 || r >= c4_pkg::ROWS || c < 0 || c >= c4_pkg::COLS)
				cell_match[j] = 1'b0;
			else
				cell_match[j] =
					(board[c[c4_pkg::COL_BITS-1:0]][r[c4_pkg::ROW_BITS-1:0]] == piece);
		end
	end

	assign hit = (win_idx < c4_pkg::window_t'(c4_pkg::WINDOWS))
		&& (piece != c4_pkg::EMPTY)
		&& (&cell_match);

endmodule

`default_nettype wire

/* src/connect_four_top.sv */
`timescale 1ns/1ps
`default_nettype none

module connect_four_top (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           right_pin,
	input  logic           left_pin,
	input  logic           drop_pin,
	output c4_pkg::board_t board_out,
	output c4_pkg::col_t   current_col,
	output c4_pkg::cell_t  current_player,
	output logic           game_over
);

	c4_pkg::buttons_t btn;
	c4_pkg::drop_req_t drop_req;
	c4_pkg::fill_t [c4_pkg::COLS-1:0] fill;
	c4_pkg::window_t win_idx;
	c4_pkg::row_t piece_row;
	logic hit;

	button_sync button_sync_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.right_pin (right_pin),
		.left_pin  (left_pin),
		.drop_pin  (drop_pin),
		.btn       (btn)
	);

	turn_control turn_control_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.btn            (btn),
		.fill           (fill),
		.hit            (hit),
		.drop_req       (drop_req),
		.win_idx        (win_idx),
		.piece_row      (piece_row),
		.current_col    (current_col),
		.current_player (current_player),
		.game_over      (game_over)
	);

	// Each column drives its own slice of the board
	for (genvar i = 0; i < c4_pkg::COLS; i++)
	begin : g_col
		column_stack #(
			.IDX (i)
		) column_stack_i (
			.clk      (clk),
			.rst_n    (rst_n),
			.drop_req (drop_req),
			.col_data (board_out[i]),
			.fill     (fill[i])
		);
	end

	// Piece colour is the current player during the scan
	line_checker line_checker_i (
		.board     (board_out),
		.win_idx   (win_idx),
		.piece_row (piece_row),
		.piece_col (current_col),
		.piece     (current_player),
		.hit       (hit)
	);

endmodule

`default_nettype wire

/* tb/connect_four_props.sv */
`timescale 1ns/1ps
`default_nettype none

module connect_four_props (
	input logic           clk,
	input logic           rst_n,
	input c4_pkg::board_t board_out,
	input c4_pkg::cell_t  current_player,
	input logic           game_over
);

	int fail_count = 0;

	// Only reset clears a finished game
	property over_holds;
		@(posedge clk) disable iff (!rst_n)
		game_over |=> game_over;
	endproperty

	property player_valid;
		@(posedge clk) disable iff (!rst_n)
		current_player != c4_pkg::EMPTY;
	endproperty

	property board_frozen;
		@(posedge clk) disable iff (!rst_n)
		game_over |=> $stable(board_out);
	endproperty

	over_holds_a: assert property (over_holds)
		else
		begin
			fail_count++;
			$error("game_over fell without a reset");
		end

	player_valid_a: assert property (player_valid)
		else
		begin
			fail_count++;
			$error("current_player is EMPTY");
		end

	board_frozen_a: assert property (board_frozen)
		else
		begin
			fail_count++;
			$error("board_out changed after the game ended");
		end

endmodule

bind connect_four_top connect_four_props props_i (
	.clk            (clk),
	.rst_n          (rst_n),
	.board_out      (board_out),
	.current_player (current_player),
	.game_over      (game_over)
);

`default_nettype wire

/* tb/connect_four_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module connect_four_tb;

	typedef enum logic [2:0] {
		ACT_LEFT,
		ACT_RIGHT,
		ACT_BOTH,
		ACT_DROP,
		ACT_RESET
	} action_t;

	// One table row holds the action and the state expected after it
	typedef struct packed {
		action_t       act;
		c4_pkg::col_t  col;
		c4_pkg::cell_t player;
		logic          over;
	} step_t;

	localparam int TIMEOUT = 100;
	localparam int IDLE_CYCLES = 20;
	localparam c4_pkg::cell_t P1 = c4_pkg::PLAYER1;
	localparam c4_pkg::cell_t P2 = c4_pkg::PLAYER2;

	logic clk;
	logic rst_n;
	logic right_pin;
	logic left_pin;
	logic drop_pin;
	c4_pkg::board_t board_out;
	c4_pkg::col_t current_col;
	c4_pkg::cell_t current_player;
	logic game_over;

	step_t steps[$];
	c4_pkg::board_t model;
	int model_fill[c4_pkg::COLS];
	c4_pkg::col_t prev_col;
	c4_pkg::cell_t prev_player;
	logic prev_over;

	connect_four_top dut_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.right_pin      (right_pin),
		.left_pin       (left_pin),
		.drop_pin       (drop_pin),
		.board_out      (board_out),
		.current_col    (current_col),
		.current_player (current_player),
		.game_over      (game_over)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Errors found");
		$fatal(1, "stopping at the first failure");
	endtask

	always @(dut_i.props_i.fail_count)
		if (dut_i.props_i.fail_count != 0)
			report_failure("a bound assertion on the DUT failed");

	task automatic check_board(input string name, input c4_pkg::board_t actual,
		input c4_pkg::board_t expected);
		if (actual !== expected)
			report_failure($sformatf("mismatch at %0t: %s is %h, expected %h",
				$time, name, actual, expected));
	endtask

	task automatic check_col(input string name, input c4_pkg::col_t actual,
		input c4_pkg::col_t expected);
		if (actual !== expected)
			report_failure($sformatf("mismatch at %0t: %s is %0d, expected %0d",
				$time, name, actual, expected));
	endtask

	task automatic check_cell(input string name, input c4_pkg::cell_t actual,
		input c4_pkg::cell_t expected);
		if (actual !== expected)
			report_failure($sformatf("mismatch at %0t: %s is %0d, expected %0d",
				$time, name, actual, expected));
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected)
			report_failure($sformatf("mismatch at %0t: %s is %b, expected %b",
				$time, name, actual, expected));
	endtask

	// Returns 2 ns after a rising edge where inputs change and outputs are read
	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic wait_col_change(input c4_pkg::col_t old_col);
		int n;
		n = 0;
		while (current_col === old_col && n < TIMEOUT)
		begin
			wait_cycles(1);
			n++;
		end
		if (n == TIMEOUT)
			report_failure("the cursor did not move within the timeout");
	endtask

	task automatic wait_player_change(input c4_pkg::cell_t old_player);
		int n;
		n = 0;
		while (current_player === old_player && n < TIMEOUT)
		begin
			wait_cycles(1);
			n++;
		end
		if (n == TIMEOUT)
			report_failure("the turn did not pass within the timeout");
	endtask

	task automatic press(input action_t act);
		right_pin = !(act == ACT_RIGHT || act == ACT_BOTH);
		left_pin = !(act == ACT_LEFT || act == ACT_BOTH);
		drop_pin = !(act == ACT_DROP);
		wait_cycles(2);
		right_pin = 1'b1;
		left_pin = 1'b1;
		drop_pin = 1'b1;
		wait_cycles(2);
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		wait_cycles(4);
		rst_n = 1'b1;
		for (int c = 0; c < c4_pkg::COLS; c++)
		begin
			model_fill[c] = 0;
			for (int r = 0; r < c4_pkg::ROWS; r++)
				model[c][r] = c4_pkg::EMPTY;
		end
	endtask

	// Piece lands on the lowest free cell and a full column takes nothing
	task automatic model_drop(input c4_pkg::col_t col, input c4_pkg::cell_t piece);
		if (!prev_over && model_fill[col] < c4_pkg::ROWS)
		begin
			model[col][model_fill[col]] = piece;
			model_fill[col]++;
		end
	endtask

	task automatic add_step(input action_t act, input c4_pkg::col_t col,
		input c4_pkg::cell_t player, input logic over);
		steps.push_back('{act, col, player, over});
	endtask

	task automatic build_table();
		add_step(ACT_RESET, 0, P1, 0);
		add_step(ACT_LEFT, 7, P1, 0);
		add_step(ACT_RIGHT, 0, P1, 0);
		add_step(ACT_BOTH, 0, P1, 0);
		for (int i = 0; i < c4_pkg::ROWS; i++)
			add_step(ACT_DROP, 0, (i % 2 == 0) ? P2 : P1, 0);
		// Ninth piece in a full column
		add_step(ACT_DROP, 0, P1, 0);
		// Vertical win in column 0
		add_step(ACT_RESET, 0, P1, 0);
		for (int i = 0; i < 3; i++)
		begin
			add_step(ACT_DROP, 0, P2, 0);
			add_step(ACT_RIGHT, 1, P2, 0);
			add_step(ACT_DROP, 1, P1, 0);
			add_step(ACT_LEFT, 0, P1, 0);
		end
		add_step(ACT_DROP, 0, P1, 1);
		add_step(ACT_RIGHT, 0, P1, 1);
		// Horizontal win closed in the middle at column 2
		add_step(ACT_RESET, 0, P1, 0);
		add_step(ACT_DROP, 0, P2, 0);
		add_step(ACT_DROP, 0, P1, 0);
		add_step(ACT_RIGHT, 1, P1, 0);
		add_step(ACT_DROP, 1, P2, 0);
		add_step(ACT_DROP, 1, P1, 0);
		add_step(ACT_RIGHT, 2, P1, 0);
		add_step(ACT_RIGHT, 3, P1, 0);
		add_step(ACT_DROP, 3, P2, 0);
		add_step(ACT_DROP, 3, P1, 0);
		add_step(ACT_LEFT, 2, P1, 0);
		add_step(ACT_DROP, 2, P1, 1);
		add_step(ACT_DROP, 2, P1, 1);
		// Rising diagonal from column 0 row 0 up to column 3 row 3
		add_step(ACT_RESET, 0, P1, 0);
		add_step(ACT_DROP, 0, P2, 0);
		add_step(ACT_RIGHT, 1, P2, 0);
		add_step(ACT_DROP, 1, P1, 0);
		add_step(ACT_DROP, 1, P2, 0);
		add_step(ACT_RIGHT, 2, P2, 0);
		add_step(ACT_DROP, 2, P1, 0);
		add_step(ACT_RIGHT, 3, P1, 0);
		add_step(ACT_DROP, 3, P2, 0);
		add_step(ACT_LEFT, 2, P2, 0);
		add_step(ACT_DROP, 2, P1, 0);
		add_step(ACT_DROP, 2, P2, 0);
		add_step(ACT_RIGHT, 3, P2, 0);
		add_step(ACT_DROP, 3, P1, 0);
		add_step(ACT_DROP, 3, P2, 0);
		add_step(ACT_RIGHT, 4, P2, 0);
		add_step(ACT_DROP, 4, P1, 0);
		add_step(ACT_LEFT, 3, P1, 0);
		add_step(ACT_DROP, 3, P1, 1);
		add_step(ACT_LEFT, 3, P1, 1);
	endtask

	initial
	begin
		step_t s;
		rst_n = 1'b0;
		right_pin = 1'b1;
		left_pin = 1'b1;
		drop_pin = 1'b1;
		prev_col = '0;
		prev_player = P1;
		prev_over = 1'b0;
		build_table();
		foreach (steps[i])
		begin
			s = steps[i];
			if (s.act == ACT_RESET)
				apply_reset();
			else
			begin
				if (s.act == ACT_DROP)
					model_drop(prev_col, prev_player);
				press(s.act);
				if (s.col != prev_col)
					wait_col_change(prev_col);
				else if (s.player != prev_player)
					wait_player_change(prev_player);
				else
					wait_cycles(IDLE_CYCLES);
			end
			check_board("board_out", board_out, model);
			check_col("current_col", current_col, s.col);
			check_cell("current_player", current_player, s.player);
			check_flag("game_over", game_over, s.over);
			prev_col = s.col;
			prev_player = s.player;
			prev_over = s.over;
		end
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
src/c4_pkg.sv
src/button_sync.sv
src/turn_control.sv
src/column_stack.sv
src/line_checker.sv
src/connect_four_top.sv
tb/connect_four_props.sv
tb/connect_four_tb.sv

/* Bender.yml */
package:
  name: connect_four

sources:
  - files:
      - src/c4_pkg.sv
      - src/button_sync.sv
      - src/turn_control.sv
      - src/column_stack.sv
      - src/line_checker.sv
      - src/connect_four_top.sv
  - target: test
    files:
      - tb/connect_four_props.sv
      - tb/connect_four_tb.sv
